/* common/io_cache_pkg.sv */
//////////////////////////////
// Shared types for the uncached IO path of the data cache
// Referenced by scoped name from the RTL and the testbench
//////////////////////////////

package io_cache_pkg;

    // IO byte address
    typedef logic [31:0] io_addr_t;

    // IO data word
    typedef logic [31:0] io_data_t;

    // One enable bit per data byte
    typedef logic [3:0] io_strb_t;

    // Request ID, echoed back with the response
    typedef logic [7:0] io_id_t;

    // Protection field, carried along but never checked
    typedef logic [2:0] io_prot_t;

    // Number of IO registers in the bank
    parameter int reg_num = 16;

    // Last operation served by the memory controller
    typedef enum logic [1:0] {
        idle,
        read_resp,
        write_resp
    } memctrl_state_t;

endpackage

/* design/scfifo.sv */
//////////////////////////////
// Single-clock FIFO with full and empty flags
// Head entry shows on data_out without a read latency
//////////////////////////////

`timescale 1ns/1ns

module scfifo #(
    parameter int addr_width = 2,
    parameter int data_width = 8
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic [data_width-1:0] data_in,
    input  logic                  push,
    output logic                  full,
    output logic [data_width-1:0] data_out,
    input  logic                  pull,
    output logic                  empty
);

    localparam int depth = 2 ** addr_width;

    //////////////////////////////
    // Storage and pointers
    //////////////////////////////

    logic [data_width-1:0] mem [depth];

    // Extra MSB is the wrap bit
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    logic do_push;
    logic do_pull;

    // Same index, opposite wrap bit -> every slot taken
    assign full = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                  (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // Pointers equal including wrap bit
    assign empty = (wr_ptr == rd_ptr);

    // Overflow and underflow requests dropped here
    assign do_push = push && !full;
    assign do_pull = pull && !empty;

    //////////////////////////////
    // Pointer update
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr[addr_width-1:0]] <= data_in;
        end
    end

    // Head of queue
    assign data_out = mem[rd_ptr[addr_width-1:0]];

endmodule

/* io_cache/io_fetcher.sv */
//////////////////////////////
// Read request stage of the IO path
// Queues reads and stalls them while writes are queued
//////////////////////////////

`timescale 1ns/1ns

module io_fetcher #(
    parameter int ostd_num = 4
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    // From the control unit
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  io_cache_pkg::io_addr_t ar_addr,
    input  io_cache_pkg::io_prot_t ar_prot,
    input  io_cache_pkg::io_id_t   ar_id,
    // Ordering flags shared with the pusher
    input  logic                  pending_wr,
    output logic                  pending_rd,
    // Queued reads to the controller
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output io_cache_pkg::io_addr_t rd_addr,
    output io_cache_pkg::io_id_t   rd_id
);

    // Stored fields: prot, id, addr
    localparam int entry_w = $bits(io_cache_pkg::io_prot_t) +
                             $bits(io_cache_pkg::io_id_t) +
                             $bits(io_cache_pkg::io_addr_t);

    logic               fifo_full;
    logic               fifo_empty;
    logic [entry_w-1:0] fifo_out;

    scfifo #(
        .addr_width ($clog2(ostd_num)),
        .data_width (entry_w)
    ) req_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .data_in  ({ar_prot, ar_id, ar_addr}),
        .push     (ar_valid && ar_ready),
        .full     (fifo_full),
        .data_out (fifo_out),
        .pull     (rd_valid && rd_ready),
        .empty    (fifo_empty)
    );

    // No new read while a write sits in the other queue
    assign ar_ready = !fifo_full && !pending_wr;

    // Prot bits stay in the top of the entry
    assign rd_addr  = fifo_out[$bits(io_cache_pkg::io_addr_t)-1:0];
    assign rd_id    = fifo_out[$bits(io_cache_pkg::io_addr_t) +: $bits(io_cache_pkg::io_id_t)];
    assign rd_valid = !fifo_empty;

    assign pending_rd = !fifo_empty;

endmodule

/* io_cache/io_pusher.sv */
//////////////////////////////
// Write request stage of the IO path
// Queues writes and stalls them while reads are queued
//////////////////////////////

`timescale 1ns/1ns

module io_pusher #(
    parameter int ostd_num = 4
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    // From the control unit, address and data as one request
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  io_cache_pkg::io_addr_t aw_addr,
    input  io_cache_pkg::io_prot_t aw_prot,
    input  io_cache_pkg::io_id_t   aw_id,
    input  io_cache_pkg::io_data_t w_data,
    input  io_cache_pkg::io_strb_t w_strb,
    // Ordering flags shared with the fetcher
    input  logic                   pending_rd,
    output logic                   pending_wr,
    // Queued writes to the controller
    output logic                   wr_valid,
    input  logic                   wr_ready,
    output io_cache_pkg::io_addr_t wr_addr,
    output io_cache_pkg::io_id_t   wr_id,
    output io_cache_pkg::io_data_t wr_data,
    output io_cache_pkg::io_strb_t wr_strb
);

    localparam int addr_w = $bits(io_cache_pkg::io_addr_t);
    localparam int data_w = $bits(io_cache_pkg::io_data_t);
    localparam int strb_w = $bits(io_cache_pkg::io_strb_t);
    localparam int id_w   = $bits(io_cache_pkg::io_id_t);

    // Stored fields from MSB: prot, id, strb, data, addr
    localparam int entry_w = $bits(io_cache_pkg::io_prot_t) + id_w + strb_w + data_w + addr_w;

    logic               fifo_full;
    logic               fifo_empty;
    logic [entry_w-1:0] fifo_out;

    scfifo #(
        .addr_width ($clog2(ostd_num)),
        .data_width (entry_w)
    ) req_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .data_in  ({aw_prot, aw_id, w_strb, w_data, aw_addr}),
        .push     (aw_valid && aw_ready),
        .full     (fifo_full),
        .data_out (fifo_out),
        .pull     (wr_valid && wr_ready),
        .empty    (fifo_empty)
    );

    // Blocked behind any queued read
    assign aw_ready = !fifo_full && !pending_rd;

    // Field split of the head entry
    assign wr_addr  = fifo_out[addr_w-1:0];
    assign wr_data  = fifo_out[addr_w +: data_w];
    assign wr_strb  = fifo_out[addr_w + data_w +: strb_w];
    assign wr_id    = fifo_out[addr_w + data_w + strb_w +: id_w];
    assign wr_valid = !fifo_empty;

    assign pending_wr = !fifo_empty;

endmodule

/* io_cache/io_memctrl.sv */
//////////////////////////////
// IO register bank behind the request queues
// Serves one queued read or write per cycle, reads first
//////////////////////////////

`timescale 1ns/1ns

module io_memctrl (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Queued reads
    input  logic                   rd_valid,
    output logic                   rd_ready,
    input  io_cache_pkg::io_addr_t rd_addr,
    input  io_cache_pkg::io_id_t   rd_id,
    // Queued writes
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  io_cache_pkg::io_addr_t wr_addr,
    input  io_cache_pkg::io_id_t   wr_id,
    input  io_cache_pkg::io_data_t wr_data,
    input  io_cache_pkg::io_strb_t wr_strb,
    // Read data channel
    output logic                   r_valid,
    input  logic                   r_ready,
    output io_cache_pkg::io_data_t r_data,
    output io_cache_pkg::io_id_t   r_id,
    // Write response channel
    output logic                   b_valid,
    input  logic                   b_ready,
    output io_cache_pkg::io_id_t   b_id
);

    localparam int idx_w  = $clog2(io_cache_pkg::reg_num);
    localparam int byte_n = $bits(io_cache_pkg::io_strb_t);

    //////////////////////////////
    // Register bank and grant
    //////////////////////////////

    io_cache_pkg::io_data_t regs [io_cache_pkg::reg_num];

    // Word index from address bits above the byte offset
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;

    logic rd_slot_free;
    logic wr_slot_free;
    logic rd_grant;
    logic wr_grant;

    assign rd_idx = rd_addr[idx_w+1:2];
    assign wr_idx = wr_addr[idx_w+1:2];

    // Response slot empty or drained this cycle
    assign rd_slot_free = !r_valid || r_ready;
    assign wr_slot_free = !b_valid || b_ready;

    // Reads win; a waiting read also holds off writes
    assign rd_ready = rd_slot_free;
    assign wr_ready = wr_slot_free && !rd_valid;

    assign rd_grant = rd_valid && rd_ready;
    assign wr_grant = wr_valid && wr_ready;

    // Byte-masked write, effective on the pull edge
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < io_cache_pkg::reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_grant) begin
            for (int b = 0; b < byte_n; b++) begin
                if (wr_strb[b]) begin
                    regs[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Response registers
    //////////////////////////////

    // Valid flags
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (rd_grant) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_grant) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // Payload sampled on the grant edge
    always_ff @(posedge aclk) begin
        if (rd_grant) begin
            r_data <= regs[rd_idx];
            r_id   <= rd_id;
        end
        if (wr_grant) begin
            b_id <= wr_id;
        end
    end

endmodule

/* io_cache/io_cache.sv */
//////////////////////////////
// Top of the uncached IO path
// Ties both request stages to the register bank
//////////////////////////////

`timescale 1ns/1ns

module io_cache #(
    parameter int ostd_num = 4
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Read request channel
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  io_cache_pkg::io_addr_t ar_addr,
    input  io_cache_pkg::io_prot_t ar_prot,
    input  io_cache_pkg::io_id_t   ar_id,
    // Write request channel
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  io_cache_pkg::io_addr_t aw_addr,
    input  io_cache_pkg::io_prot_t aw_prot,
    input  io_cache_pkg::io_id_t   aw_id,
    input  io_cache_pkg::io_data_t w_data,
    input  io_cache_pkg::io_strb_t w_strb,
    // Read data channel
    output logic                   r_valid,
    input  logic                   r_ready,
    output io_cache_pkg::io_data_t r_data,
    output io_cache_pkg::io_id_t   r_id,
    // Write response channel
    output logic                   b_valid,
    input  logic                   b_ready,
    output io_cache_pkg::io_id_t   b_id
);

    //////////////////////////////
    // Internal channels
    //////////////////////////////

    // Cross-coupled ordering flags
    logic pending_rd;
    logic pending_wr;

    // Queued reads
    logic                   rd_valid;
    logic                   rd_ready;
    io_cache_pkg::io_addr_t rd_addr;
    io_cache_pkg::io_id_t   rd_id;

    // Queued writes
    logic                   wr_valid;
    logic                   wr_ready;
    io_cache_pkg::io_addr_t wr_addr;
    io_cache_pkg::io_id_t   wr_id;
    io_cache_pkg::io_data_t wr_data;
    io_cache_pkg::io_strb_t wr_strb;

    io_fetcher #(
        .ostd_num (ostd_num)
    ) fetcher_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .ar_prot    (ar_prot),
        .ar_id      (ar_id),
        .pending_wr (pending_wr),
        .pending_rd (pending_rd),
        .rd_valid   (rd_valid),
        .rd_ready   (rd_ready),
        .rd_addr    (rd_addr),
        .rd_id      (rd_id)
    );

    io_pusher #(
        .ostd_num (ostd_num)
    ) pusher_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .aw_prot    (aw_prot),
        .aw_id      (aw_id),
        .w_data     (w_data),
        .w_strb     (w_strb),
        .pending_rd (pending_rd),
        .pending_wr (pending_wr),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_addr    (wr_addr),
        .wr_id      (wr_id),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb)
    );

    // Register bank and both response channels
    io_memctrl memctrl_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_addr  (rd_addr),
        .rd_id    (rd_id),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_addr  (wr_addr),
        .wr_id    (wr_id),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_id     (r_id),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_id     (b_id)
    );

endmodule

/* sim/io_cache_asserts.sv */
//////////////////////////////
// Handshake and ordering checks for the IO path
// Bound into io_cache at the end of this file
//////////////////////////////

`timescale 1ns/1ns

module io_cache_asserts (
    input logic                   aclk,
    input logic                   rst_n,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input io_cache_pkg::io_addr_t ar_addr,
    input io_cache_pkg::io_id_t   ar_id,
    input logic                   aw_valid,
    input logic                   aw_ready,
    input io_cache_pkg::io_addr_t aw_addr,
    input io_cache_pkg::io_id_t   aw_id,
    input io_cache_pkg::io_data_t w_data,
    input io_cache_pkg::io_strb_t w_strb,
    input logic                   r_valid,
    input logic                   r_ready,
    input io_cache_pkg::io_data_t r_data,
    input io_cache_pkg::io_id_t   r_id,
    input logic                   b_valid,
    input logic                   b_ready,
    input io_cache_pkg::io_id_t   b_id,
    input logic                   pending_rd,
    input logic                   pending_wr
);

    // Failed checks, read back by the testbench
    int fail_count = 0;

    //////////////////////////////
    // Valid held until ready
    //////////////////////////////

    ar_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
    else begin
        fail_count++;
        $error("ar request changed before it was accepted");
    end

    aw_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_id) &&
                                  $stable(w_data) && $stable(w_strb))
    else begin
        fail_count++;
        $error("aw request changed before it was accepted");
    end

    r_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_id))
    else begin
        fail_count++;
        $error("read response changed before it was taken");
    end

    b_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b_id))
    else begin
        fail_count++;
        $error("write response changed before it was taken");
    end

    //////////////////////////////
    // Ordering between the queues
    //////////////////////////////

    // No read accepted past a queued write
    ar_blocked: assert property (@(posedge aclk) disable iff (!rst_n)
        pending_wr |-> !ar_ready)
    else begin
        fail_count++;
        $error("ar_ready high while a write is queued");
    end

    aw_blocked: assert property (@(posedge aclk) disable iff (!rst_n)
        pending_rd |-> !aw_ready)
    else begin
        fail_count++;
        $error("aw_ready high while a read is queued");
    end

endmodule

bind io_cache io_cache_asserts asserts_inst (.*);

/* sim/io_cache_tb.sv */
//////////////////////////////
// Testbench for the uncached IO path, driven by the stimulus file
// Applies random response back-pressure and checks every response
//////////////////////////////

`timescale 1ns/1ns

module io_cache_tb;

    localparam int ostd_num   = 4;
    localparam int wait_limit = 200;

    logic                   aclk;
    logic                   rst_n;
    logic                   ar_valid;
    logic                   ar_ready;
    io_cache_pkg::io_addr_t ar_addr;
    io_cache_pkg::io_prot_t ar_prot;
    io_cache_pkg::io_id_t   ar_id;
    logic                   aw_valid;
    logic                   aw_ready;
    io_cache_pkg::io_addr_t aw_addr;
    io_cache_pkg::io_prot_t aw_prot;
    io_cache_pkg::io_id_t   aw_id;
    io_cache_pkg::io_data_t w_data;
    io_cache_pkg::io_strb_t w_strb;
    logic                   r_valid;
    logic                   r_ready;
    io_cache_pkg::io_data_t r_data;
    io_cache_pkg::io_id_t   r_id;
    logic                   b_valid;
    logic                   b_ready;
    io_cache_pkg::io_id_t   b_id;

    // Scoreboards in issue order
    io_cache_pkg::io_id_t   rd_id_q[$];
    io_cache_pkg::io_data_t rd_data_q[$];
    io_cache_pkg::io_id_t   wr_id_q[$];

    int          err_count;
    int          timeout_count;
    logic [15:0] lfsr;

    // Read-response stall for the burst test
    bit stall_rd;
    bit stall_seen;
    bit stall_blocked;
    int stall_accepted;

    io_cache #(
        .ostd_num (ostd_num)
    ) io_cache_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_prot  (ar_prot),
        .ar_id    (ar_id),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_prot  (aw_prot),
        .aw_id    (aw_id),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_id     (r_id),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_id     (b_id)
    );

    // 8 ns clock
    always #4 aclk = ~aclk;

    //////////////////////////////
    // Random back-pressure
    //////////////////////////////

    // Galois LFSR, taps for a 16-bit maximal sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic random_bit(output bit b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // Ready about three cycles in four
    always @(posedge aclk) begin
        bit b0;
        bit b1;
        bit b2;
        bit b3;
        #1;
        random_bit(b0);
        random_bit(b1);
        random_bit(b2);
        random_bit(b3);
        r_ready = !stall_rd && (b0 || b1);
        b_ready = b2 || b3;
    end

    //////////////////////////////
    // Response checking
    //////////////////////////////

    task automatic check_read();
        io_cache_pkg::io_id_t   exp_id;
        io_cache_pkg::io_data_t exp_data;
        assert (rd_id_q.size() != 0) else begin
            err_count++;
            $display("Read response id %h arrived at %0t ns with no read outstanding", r_id, $time);
        end
        if (rd_id_q.size() != 0) begin
            exp_id   = rd_id_q.pop_front();
            exp_data = rd_data_q.pop_front();
            assert (r_id == exp_id) else begin
                err_count++;
                $display("[ERROR] %0t ns: read id %h, expected %h", $time, r_id, exp_id);
            end
            assert (r_data == exp_data) else begin
                err_count++;
                $display("[ERROR] %0t ns: read id %h data %h, expected %h",
                         $time, r_id, r_data, exp_data);
            end
        end
    endtask

    task automatic check_write();
        io_cache_pkg::io_id_t exp_id;
        assert (wr_id_q.size() != 0) else begin
            err_count++;
            $display("Write response id %h arrived at %0t ns with no write outstanding", b_id, $time);
        end
        if (wr_id_q.size() != 0) begin
            exp_id = wr_id_q.pop_front();
            assert (b_id == exp_id) else begin
                err_count++;
                $display("[ERROR] %0t ns: write response id %h, expected %h", $time, b_id, exp_id);
            end
        end
    endtask

    // Values are stable at the falling edge, transfer on the next rising one
    always @(negedge aclk) begin
        if (rst_n) begin
            if (r_valid && r_ready) begin
                check_read();
            end
            if (b_valid && b_ready) begin
                check_write();
            end
        end
    end

    //////////////////////////////
    // Request driving
    //////////////////////////////

    task automatic issue_read(input io_cache_pkg::io_addr_t addr,
                              input io_cache_pkg::io_id_t id, output bit ok);
        int waited;
        bit hs;
        waited   = 0;
        hs       = 1'b0;
        ar_addr  = addr;
        ar_id    = id;
        ar_prot  = 3'b000;
        ar_valid = 1'b1;
        while (!hs && waited < wait_limit) begin
            @(negedge aclk);
            hs = ar_ready;
            // Queue full behind the stalled response, let it drain
            if (!hs && stall_rd && stall_accepted > ostd_num) begin
                stall_blocked = 1'b1;
                stall_rd      = 1'b0;
            end
            @(posedge aclk);
            #1;
            waited++;
        end
        ar_valid = 1'b0;
        if (hs && stall_rd) begin
            stall_accepted++;
        end
        ok = hs;
        if (!hs) begin
            timeout_count++;
            $display("Timeout: ar_ready stayed low for %0d cycles on read id %h", wait_limit, id);
        end
    endtask

    task automatic issue_write(input io_cache_pkg::io_addr_t addr,
                               input io_cache_pkg::io_id_t id,
                               input io_cache_pkg::io_data_t data,
                               input io_cache_pkg::io_strb_t strb, output bit ok);
        int waited;
        bit hs;
        waited   = 0;
        hs       = 1'b0;
        aw_addr  = addr;
        aw_id    = id;
        aw_prot  = 3'b000;
        w_data   = data;
        w_strb   = strb;
        aw_valid = 1'b1;
        while (!hs && waited < wait_limit) begin
            @(negedge aclk);
            hs = aw_ready;
            @(posedge aclk);
            #1;
            waited++;
        end
        aw_valid = 1'b0;
        ok = hs;
        if (!hs) begin
            timeout_count++;
            $display("Timeout: aw_ready stayed low for %0d cycles on write id %h", wait_limit, id);
        end
    endtask

    // Wait until every issued request has its response
    task automatic drain_responses(output bit ok);
        int waited;
        waited = 0;
        while ((rd_id_q.size() != 0 || wr_id_q.size() != 0) && waited < wait_limit) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        ok = (rd_id_q.size() == 0 && wr_id_q.size() == 0);
        if (!ok) begin
            timeout_count++;
            $display("Timeout: %0d read and %0d write responses never arrived",
                     rd_id_q.size(), wr_id_q.size());
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int                     fd;
        int                     c;
        int                     n;
        int                     asrt_count;
        io_cache_pkg::io_addr_t f_addr;
        io_cache_pkg::io_id_t   f_id;
        io_cache_pkg::io_data_t f_data;
        io_cache_pkg::io_strb_t f_strb;
        io_cache_pkg::io_data_t f_exp;
        bit                     ok;
        bit                     done;
        aclk           = 1'b0;
        rst_n          = 1'b0;
        ar_valid       = 1'b0;
        ar_addr        = '0;
        ar_prot        = '0;
        ar_id          = '0;
        aw_valid       = 1'b0;
        aw_addr        = '0;
        aw_prot        = '0;
        aw_id          = '0;
        w_data         = '0;
        w_strb         = '0;
        r_ready        = 1'b0;
        b_ready        = 1'b0;
        lfsr           = 16'd92;
        err_count      = 0;
        timeout_count  = 0;
        stall_rd       = 1'b0;
        stall_seen     = 1'b0;
        stall_blocked  = 1'b0;
        stall_accepted = 0;
        done           = 1'b0;

        fd = $fopen("sim/io_cache_input.txt", "r");
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        // No response before any request
        repeat (2) begin
            @(negedge aclk);
            assert (!r_valid && !b_valid) else begin
                err_count++;
                $display("[ERROR] %0t ns: response valid high before any request", $time);
            end
        end
        @(posedge aclk);
        #1;

        if (fd == 0) begin
            err_count++;
            $display("Could not open the stimulus file sim/io_cache_input.txt");
            done = 1'b1;
        end

        // One request per line, comment lines start with #
        while (!done) begin
            c = $fgetc(fd);
            if (c < 0) begin
                done = 1'b1;
            end else if (c == int'("#")) begin
                while (c >= 0 && c != int'("\n")) begin
                    c = $fgetc(fd);
                end
            end else if (c == int'("R") || c == int'("W") || c == int'("S")) begin
                n = $fscanf(fd, "%h %h %h %h %h", f_addr, f_id, f_data, f_strb, f_exp);
                if (n != 5) begin
                    err_count++;
                    $display("Malformed line in the stimulus file");
                    done = 1'b1;
                end else if (c == int'("S")) begin
                    // Empty pipe first, then hold r_ready low
                    drain_responses(ok);
                    done = !ok;
                    @(negedge aclk);
                    stall_rd       = 1'b1;
                    stall_seen     = 1'b1;
                    stall_accepted = 0;
                    @(posedge aclk);
                    #1;
                end else if (c == int'("W")) begin
                    wr_id_q.push_back(f_id);
                    issue_write(f_addr, f_id, f_data, f_strb, ok);
                    done = !ok;
                end else begin
                    rd_id_q.push_back(f_id);
                    rd_data_q.push_back(f_exp);
                    issue_read(f_addr, f_id, ok);
                    done = !ok;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (stall_rd) begin
            @(negedge aclk);
            stall_rd = 1'b0;
            @(posedge aclk);
            #1;
        end
        drain_responses(ok);
        // Idle tail catches any extra response
        repeat (4) @(posedge aclk);

        assert (!stall_seen || stall_blocked) else begin
            err_count++;
            $display("ar_ready never dropped during the stalled read burst");
        end

        asrt_count = io_cache_inst.asserts_inst.fail_count;
        $display("Closing counts: %0d check errors, %0d assertion failures, %0d timeouts",
                 err_count, asrt_count, timeout_count);
        if (err_count == 0 && asrt_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim/io_cache_input.txt */
# op addr id data strb expected, all hex; R checks expected, W ignores it
# S empties the pipe and stalls r_ready until ar_ready drops, other fields unused
R 10000000 01 00000000 0 00000000
R 10000004 02 00000000 0 00000000
R 1000003c 03 00000000 0 00000000
W 10000000 10 deadbeef f 00000000
W 10000004 11 12345678 f 00000000
W 10000008 12 a5a5a5a5 f 00000000
R 10000000 13 00000000 0 deadbeef
R 10000004 14 00000000 0 12345678
R 10000008 15 00000000 0 a5a5a5a5
W 1000000c 20 11223344 f 00000000
W 1000000c 21 aabbccdd 5 00000000
R 1000000c 22 00000000 0 11bb33dd
W 10000004 23 ffffffff 8 00000000
R 10000004 24 00000000 0 ff345678
W 10000010 25 cafef00d 6 00000000
R 10000010 26 00000000 0 00fef000
W 10000014 30 00000001 f 00000000
R 10000014 31 00000000 0 00000001
W 10000014 32 00000002 f 00000000
R 10000014 33 00000000 0 00000002
W 10000014 34 000000ff 1 00000000
R 10000014 35 00000000 0 000000ff
R 10000054 36 00000000 0 000000ff
S 00000000 00 00000000 0 00000000
R 10000000 40 00000000 0 deadbeef
R 10000004 41 00000000 0 ff345678
R 10000008 42 00000000 0 a5a5a5a5
R 1000000c 43 00000000 0 11bb33dd
R 10000010 44 00000000 0 00fef000
R 10000014 45 00000000 0 000000ff
R 1000003c 46 00000000 0 00000000
W 1000003c 50 87654321 f 00000000
R 1000003c 51 00000000 0 87654321

/* list.f */
common/io_cache_pkg.sv
design/scfifo.sv
io_cache/io_fetcher.sv
io_cache/io_pusher.sv
io_cache/io_memctrl.sv
io_cache/io_cache.sv
sim/io_cache_asserts.sv
sim/io_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the IO path testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --top-module io_cache_tb -f list.f -o io_cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/io_cache_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi

if ! grep -q "Verification passed" "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
